// ==== verilog/periph_bus_pkg.sv ====
////////////////////////////////////////
// Peripheral bus definitions
// Native data bus of the core: access
// size code, request and response
////////////////////////////////////////

package periph_bus_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 11;

    // Active low size code as driven by the core
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11  // No access this cycle
    } access_size_e;

    // Request from the core, valid every cycle
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;       // Low 8, 16 or 32 bits valid on write
        access_size_e      write_size;
        access_size_e      read_size;   // Held active until ready
    } bus_req_t;

    // Response back to the core
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              ready;
    } bus_rsp_t;

endpackage

// ==== verilog/periph_map_pkg.sv ====
////////////////////////////////////////
// Peripheral address map
// Slot numbers, register offsets and
// the pin routing types
////////////////////////////////////////

package periph_map_pkg;

    localparam int NUM_SLOTS = 16;  // Per region

    // Populated slots
    localparam logic [3:0] SLOT_GPIO = 4'd1;   // Full region
    localparam logic [3:0] SLOT_CRC  = 4'd6;   // Full region
    localparam logic [3:0] SLOT_PWM  = 4'd5;   // Byte region

    // One 8 bit pin bus per slot
    typedef logic [NUM_SLOTS-1:0][7:0] pin_bank_t;

    // GPIO register offsets within the 64 byte slot
    typedef enum logic [5:0] {
        GPIO_OUT   = 6'h00,
        GPIO_IN    = 6'h04,
        GPIO_AUDIO = 6'h10,
        GPIO_FUNC  = 6'h20  // One word per pin from here
    } gpio_reg_e;

    // CRC register offsets
    typedef enum logic [5:0] {
        CRC_DATA  = 6'h00,
        CRC_CLEAR = 6'h04
    } crc_reg_e;

    // Output function select for one pin
    typedef struct packed {
        logic       byte_region;  // Take the pin from the byte region
        logic [3:0] slot;
    } func_sel_t;

endpackage

// ==== verilog/gpio_ctrl.sv ====
////////////////////////////////////////
// GPIO block
// Output and audio registers, input
// readback and per-pin function select
////////////////////////////////////////

`timescale 1ns/1ps

module gpio_ctrl
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  bus_req_t  i_req,          // Already gated by the hub
    input  logic [7:0] i_ui_in,
    input  pin_bank_t i_user_pins,
    input  pin_bank_t i_byte_pins,
    output bus_rsp_t  o_rsp,
    output logic [7:0] o_gpio_out,
    output logic [7:0] o_uo_out,
    output logic      o_audio_select
);

    logic [7:0] gpio_out_r;
    logic [2:0] audio_sel_r;
    func_sel_t  func_sel_r [8];

    logic [5:0] offset;
    logic       wr_en;
    logic       func_hit;
    logic [2:0] func_pin;

    assign offset   = i_req.addr[5:0];
    assign wr_en    = i_req.write_size != SIZE_NONE;
    assign func_hit = (offset & 6'h23) == GPIO_FUNC;  // Word aligned, 0x20 to 0x3C
    assign func_pin = offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_r  <= 8'h00;
            audio_sel_r <= 3'b000;
            // Every pin starts on the GPIO slot
            for (int p = 0; p < 8; p++) begin
                func_sel_r[p] <= '{byte_region: 1'b0, slot: SLOT_GPIO};
            end
        end else if (wr_en) begin
            if (offset == GPIO_OUT) gpio_out_r <= i_req.wdata[7:0];
            if (offset == GPIO_AUDIO) audio_sel_r <= i_req.wdata[2:0];
            if (func_hit) func_sel_r[func_pin] <= func_sel_t'(i_req.wdata[4:0]);
        end
    end

    // Register readback
    always_comb begin
        o_rsp.ready = 1'b1;
        if (func_hit) begin
            o_rsp.rdata = DATA_W'(func_sel_r[func_pin]);
        end else begin
            case (offset)
                GPIO_OUT:   o_rsp.rdata = DATA_W'(gpio_out_r);
                GPIO_IN:    o_rsp.rdata = DATA_W'(i_ui_in);
                GPIO_AUDIO: o_rsp.rdata = DATA_W'(audio_sel_r);
                default:    o_rsp.rdata = '0;
            endcase
        end
    end

    // Pin p takes bit p of the selected slot's pin bus
    always_comb begin
        for (int p = 0; p < 8; p++) begin
            if (func_sel_r[p].byte_region) begin
                o_uo_out[p] = i_byte_pins[func_sel_r[p].slot][p];
            end else begin
                o_uo_out[p] = i_user_pins[func_sel_r[p].slot][p];
            end
        end
    end

    assign o_gpio_out     = gpio_out_r;
    assign o_audio_select = audio_sel_r[2];  // Low bits kept for readback only

endmodule

// ==== verilog/crc16_engine.sv ====
////////////////////////////////////////
// CRC-16 engine
// Bit-serial CRC-16-CCITT, MSB first,
// one data bit per clock
////////////////////////////////////////

`timescale 1ns/1ps

module crc16_engine
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
#(
    parameter logic [15:0] CRC_INIT = 16'hFFFF
) (
    input  logic     clk,
    input  logic     rst_n,
    input  bus_req_t i_req,
    output bus_rsp_t o_rsp,
    output logic [7:0] o_pins
);

    localparam logic [15:0] POLY = 16'h1021;

    typedef enum logic {
        ST_IDLE,
        ST_SHIFT
    } crc_state_e;

    crc_state_e  state;
    logic [15:0] crc_r;
    logic [7:0]  shift_r;   // Data byte, MSB goes in first
    logic [2:0]  bit_cnt;

    logic [5:0]  offset;
    logic        wr_en;
    logic        start;
    logic        clear;
    logic        feedback;

    assign offset   = i_req.addr[5:0];
    assign wr_en    = i_req.write_size != SIZE_NONE;
    assign clear    = wr_en && (offset == CRC_CLEAR);
    assign start    = wr_en && (offset == CRC_DATA) && (state == ST_IDLE);  // Busy drops data
    assign feedback = crc_r[15] ^ shift_r[7];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            crc_r   <= CRC_INIT;
            bit_cnt <= 3'd0;
        end else if (clear) begin
            state   <= ST_IDLE;          // Also abandons a byte in flight
            crc_r   <= CRC_INIT;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        bit_cnt <= 3'd0;
                        state   <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    crc_r   <= {crc_r[14:0], 1'b0} ^ (feedback ? POLY : 16'h0000);
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shift_r <= i_req.wdata[7:0];
        end else if (state == ST_SHIFT) begin
            shift_r <= {shift_r[6:0], 1'b0};
        end
    end

    // Reads stall while a byte is being shifted
    assign o_rsp.ready = state == ST_IDLE;
    assign o_rsp.rdata = (offset == CRC_DATA) ? DATA_W'(crc_r) : '0;
    assign o_pins      = crc_r[7:0];

endmodule

// ==== verilog/pwm_byte.sv ====
////////////////////////////////////////
// 8 bit PWM
// Free-running counter compared with a
// duty register, byte slot peripheral
////////////////////////////////////////

`timescale 1ns/1ps

module pwm_byte (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] i_addr,
    input  logic       i_write,
    input  logic [7:0] i_wdata,
    output logic [7:0] o_rdata,
    output logic [7:0] o_pins
);

    logic [7:0] duty_r;
    logic [7:0] count_r;
    logic       duty_hit;
    logic       wave;

    assign duty_hit = i_addr == 4'h0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty_r  <= 8'h00;       // Output stays low until a duty is set
            count_r <= 8'h00;
        end else begin
            count_r <= count_r + 8'd1;  // Wraps every 256 cycles
            if (i_write && duty_hit) duty_r <= i_wdata;
        end
    end

    // High for duty_r cycles out of every 256
    assign wave = count_r < duty_r;

    assign o_rdata = duty_hit ? duty_r : 8'h00;
    assign o_pins  = {8{wave}};

endmodule

// ==== verilog/periph_hub.sv ====
////////////////////////////////////////
// Peripheral hub
// Decodes the core's data bus to one
// slot, buffers read data until the core
// completes the read, routes pin buses
////////////////////////////////////////

`timescale 1ns/1ps

module periph_hub
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
#(
    parameter logic [15:0] CRC_INIT = 16'hFFFF
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic [7:0] i_ui_in,
    input  bus_req_t i_req,
    input  logic     i_read_complete,
    output bus_rsp_t o_rsp,
    output logic [7:0] o_uo_out,
    output logic     o_audio,
    output logic     o_audio_select
);

    logic              byte_region;
    logic [3:0]        full_slot;
    logic [3:0]        byte_slot;
    logic [NUM_SLOTS-1:0] full_sel;
    logic [NUM_SLOTS-1:0] byte_sel;

    logic              read_req;
    logic              hold;
    logic              ready_r;
    logic [DATA_W-1:0] rdata_r;
    logic [DATA_W-1:0] slot_rdata;
    logic              slot_ready;
    bus_req_t          held_req;

    bus_rsp_t          full_rsp [NUM_SLOTS];
    logic [7:0]        byte_rdata [NUM_SLOTS];
    pin_bank_t         user_pins;
    pin_bank_t         byte_pins;

    bus_rsp_t          gpio_rsp;
    bus_rsp_t          crc_rsp;
    logic [7:0]        gpio_pins;
    logic [7:0]        crc_pins;
    logic [7:0]        pwm_rdata;
    logic [7:0]        pwm_pins;

    // Per-slot copy of the request, sizes forced off when not selected
    function automatic bus_req_t slot_req(bus_req_t req, logic sel);
        bus_req_t gated;
        gated = req;
        if (!sel) begin
            gated.write_size = SIZE_NONE;
            gated.read_size  = SIZE_NONE;
        end
        return gated;
    endfunction

    assign byte_region = i_req.addr[10];
    assign full_slot   = i_req.addr[9:6];
    assign byte_slot   = i_req.addr[7:4];
    assign read_req    = i_req.read_size != SIZE_NONE;

    always_comb begin
        full_sel = '0;
        byte_sel = '0;
        full_sel[full_slot] = !byte_region;
        byte_sel[byte_slot] = byte_region;
    end

    // No second read while a result is held
    always_comb begin
        held_req = i_req;
        if (ready_r) held_req.read_size = SIZE_NONE;
    end

    // Empty slots answer at once with zero
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            full_rsp[s]   = '{rdata: '0, ready: 1'b1};
            byte_rdata[s] = 8'h00;
            user_pins[s]  = 8'h00;
            byte_pins[s]  = 8'h00;
        end
        full_rsp[SLOT_GPIO]   = gpio_rsp;
        full_rsp[SLOT_CRC]    = crc_rsp;
        byte_rdata[SLOT_PWM]  = pwm_rdata;
        user_pins[SLOT_GPIO]  = gpio_pins;
        user_pins[SLOT_CRC]   = crc_pins;
        byte_pins[SLOT_PWM]   = pwm_pins;
    end

    always_comb begin
        if (byte_region) begin
            slot_rdata = {24'h0, byte_rdata[byte_slot]};
            slot_ready = 1'b1;                  // Byte slots never stall
        end else begin
            slot_rdata = full_rsp[full_slot].rdata;
            slot_ready = full_rsp[full_slot].ready;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) hold <= 1'b0;
            if (!hold && slot_ready && read_req) hold <= 1'b1;
            ready_r <= read_req && slot_ready;
        end
    end

    // Latched once per read
    always_ff @(posedge clk) begin
        if (!hold && slot_ready && read_req) rdata_r <= slot_rdata;
    end

    assign o_rsp.rdata = rdata_r;
    assign o_rsp.ready = ready_r || (i_req.write_size != SIZE_NONE);  // Writes never wait

    gpio_ctrl u_gpio_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req          (slot_req(held_req, full_sel[SLOT_GPIO])),
        .i_ui_in        (i_ui_in),
        .i_user_pins    (user_pins),
        .i_byte_pins    (byte_pins),
        .o_rsp          (gpio_rsp),
        .o_gpio_out     (gpio_pins),
        .o_uo_out       (o_uo_out),
        .o_audio_select (o_audio_select)
    );

    crc16_engine #(
        .CRC_INIT (CRC_INIT)
    ) u_crc16_engine (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_req  (slot_req(held_req, full_sel[SLOT_CRC])),
        .o_rsp  (crc_rsp),
        .o_pins (crc_pins)
    );

    pwm_byte u_pwm_byte (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_addr  (i_req.addr[3:0]),
        .i_write (byte_sel[SLOT_PWM] && (i_req.write_size != SIZE_NONE)),
        .i_wdata (i_req.wdata[7:0]),
        .o_rdata (pwm_rdata),
        .o_pins  (pwm_pins)
    );

    assign o_audio = byte_pins[SLOT_PWM][7];

endmodule

// ==== verif/tb_periph_tasks.svh ====
////////////////////////////////////////
// Hub testbench helpers
// Bus read and write, random numbers
// and a CRC-16-CCITT reference
////////////////////////////////////////

// Value check, counted and reported on the spot
task automatic expect_value(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
        errors++;
        $display("FAIL %s got %h expected %h", name, got, exp);
    end
endtask

function automatic logic [31:0] xorshift_next();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
endfunction

// MSB first, polynomial 0x1021
function automatic logic [15:0] crc_ccitt_byte(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
        fb = c[15] ^ data[i];
        c  = {c[14:0], 1'b0};
        if (fb) c = c ^ 16'h1021;
    end
    return c;
endfunction

function automatic logic [10:0] func_addr(input int pin);
    return GPIO_BASE + 11'(GPIO_FUNC) + 11'(4 * pin);
endfunction

// Called just after a falling edge, returns just after one
task automatic write_reg(input logic [10:0] addr, input logic [31:0] data,
                         input access_size_e size);
    req.addr       = addr;
    req.wdata      = data;
    req.write_size = size;
    #1;
    assert (rsp.ready) else begin
        errors++;
        $display("Write to address %h was not accepted in its own cycle", addr);
    end
    @(negedge clk);
    req.write_size = SIZE_NONE;
endtask

task automatic read_reg(input logic [10:0] addr, input access_size_e size,
                        output logic [31:0] data);
    int cycles;
    req.addr      = addr;
    req.read_size = size;
    cycles        = 0;
    @(negedge clk);
    while (!rsp.ready && cycles < READ_TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (!rsp.ready) begin
        timeouts++;
        $display("Timed out waiting for read data from address %h", addr);
    end
    data          = rsp.rdata;
    req.read_size = SIZE_NONE;  // Withdraw and complete together
    read_complete = 1'b1;
    @(negedge clk);
    read_complete = 1'b0;
    expect_value("o_rsp.ready", rsp.ready, 32'h0);
endtask

// One full PWM period seen on the audio output and on pin 7
task automatic count_pwm_highs(output int audio_highs, output int pin_highs);
    audio_highs = 0;
    pin_highs   = 0;
    repeat (256) begin
        @(negedge clk);
        if (audio) audio_highs++;
        if (uo_out[7]) pin_highs++;
    end
endtask

// ==== verif/tb_periph_hub.sv ====
////////////////////////////////////////
// Peripheral hub testbench
// Runs GPIO, CRC, PWM and the read
// protocol over the native data bus
////////////////////////////////////////

`timescale 1ns/1ps

module tb_periph_hub
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
();

    localparam logic [15:0] CRC_SEED     = 16'hFFFF;
    localparam logic [31:0] RAND_SEED    = 32'hb98e_ca80;
    localparam int          READ_TIMEOUT = 40;  // CRC needs about 10 cycles

    localparam logic [10:0] GPIO_BASE  = {1'b0, SLOT_GPIO, 6'h00};
    localparam logic [10:0] CRC_BASE   = {1'b0, SLOT_CRC, 6'h00};
    localparam logic [10:0] PWM_BASE   = {1'b1, 2'b00, SLOT_PWM, 4'h0};
    localparam logic [10:0] EMPTY_FULL = {1'b0, 4'd3, 6'h00};
    localparam logic [10:0] EMPTY_BYTE = {1'b1, 2'b00, 4'd6, 4'h0};

    logic        clk;
    logic        rst_n;
    logic [7:0]  ui_in;
    bus_req_t    req;
    logic        read_complete;
    bus_rsp_t    rsp;
    logic [7:0]  uo_out;
    logic        audio;
    logic        audio_select;

    int          errors;
    int          timeouts;
    logic [31:0] rand_state;

    `include "tb_periph_tasks.svh"

    periph_hub #(
        .CRC_INIT (CRC_SEED)
    ) u_periph_hub (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_req           (req),
        .i_read_complete (read_complete),
        .o_rsp           (rsp),
        .o_uo_out        (uo_out),
        .o_audio         (audio),
        .o_audio_select  (audio_select)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] value;
        logic [15:0] crc_exp;
        int          audio_highs;
        int          pin_highs;

        errors        = 0;
        timeouts      = 0;
        rand_state    = RAND_SEED;
        rst_n         = 1'b0;
        ui_in         = 8'h00;
        read_complete = 1'b0;
        req = '{addr: '0, wdata: '0, write_size: SIZE_NONE, read_size: SIZE_NONE};
        repeat (10) @(negedge clk);

        expect_value("o_rsp.ready", rsp.ready, 32'h0);
        expect_value("o_audio_select", audio_select, 32'h0);
        expect_value("o_uo_out", uo_out, 32'h0);
        rst_n = 1'b1;
        for (int p = 0; p < 8; p++) begin
            read_reg(func_addr(p), SIZE_WORD, rdata);
            expect_value("o_rsp.rdata (FUNC)", rdata, 32'h1);  // GPIO slot
        end

        // Every pin still follows the GPIO output register
        repeat (3) begin
            value = xorshift_next();
            write_reg(GPIO_BASE + 11'(GPIO_OUT), value, SIZE_WORD);
            expect_value("o_uo_out", uo_out, value[7:0]);
            read_reg(GPIO_BASE + 11'(GPIO_OUT), SIZE_WORD, rdata);
            expect_value("o_rsp.rdata (OUT)", rdata, value[7:0]);
            ui_in = value[23:16];
            read_reg(GPIO_BASE + 11'(GPIO_IN), SIZE_WORD, rdata);
            expect_value("o_rsp.rdata (IN)", rdata, ui_in);
        end

        // Move the CRC off its start value so that CLEAR has work to do
        value = xorshift_next();
        write_reg(CRC_BASE + 11'(CRC_DATA), value, SIZE_BYTE);
        read_reg(CRC_BASE + 11'(CRC_DATA), SIZE_WORD, rdata);
        expect_value("o_rsp.rdata (CRC)", rdata, crc_ccitt_byte(CRC_SEED, value[7:0]));
        write_reg(CRC_BASE + 11'(CRC_CLEAR), 32'h0, SIZE_WORD);
        read_reg(CRC_BASE + 11'(CRC_DATA), SIZE_WORD, rdata);
        expect_value("o_rsp.rdata (CRC)", rdata, CRC_SEED);
        crc_exp = CRC_SEED;
        repeat (6) begin
            value = xorshift_next();
            write_reg(CRC_BASE + 11'(CRC_DATA), value, SIZE_BYTE);
            crc_exp = crc_ccitt_byte(crc_exp, value[7:0]);
            read_reg(CRC_BASE + 11'(CRC_DATA), SIZE_WORD, rdata);  // Waits out the shift
            expect_value("o_rsp.rdata (CRC)", rdata, crc_exp);
        end
        read_reg(EMPTY_BYTE, SIZE_BYTE, rdata);
        expect_value("o_rsp.rdata (empty byte slot)", rdata, 32'h0);
        read_reg(EMPTY_FULL, SIZE_WORD, rdata);
        expect_value("o_rsp.rdata (empty full slot)", rdata, 32'h0);

        // Pin 2 to an empty slot, pin 3 to the CRC, pin 7 to the PWM
        write_reg(GPIO_BASE + 11'(GPIO_OUT), {24'h0, 4'hF, ~crc_exp[3], 3'b111}, SIZE_WORD);
        write_reg(func_addr(2), 32'h03, SIZE_WORD);
        write_reg(func_addr(3), 32'(SLOT_CRC), SIZE_WORD);
        write_reg(func_addr(7), {27'h0, 1'b1, SLOT_PWM}, SIZE_WORD);
        expect_value("o_uo_out", uo_out, {1'b0, 3'b111, crc_exp[3], 1'b0, 2'b11});
        read_reg(func_addr(2), SIZE_WORD, rdata);
        expect_value("o_rsp.rdata (FUNC)", rdata, 32'h03);
        read_reg(func_addr(3), SIZE_WORD, rdata);
        expect_value("o_rsp.rdata (FUNC)", rdata, 32'(SLOT_CRC));
        read_reg(func_addr(7), SIZE_WORD, rdata);
        expect_value("o_rsp.rdata (FUNC)", rdata, {27'h0, 1'b1, SLOT_PWM});
        count_pwm_highs(audio_highs, pin_highs);  // Duty still 0
        expect_value("o_uo_out[7] high cycles", pin_highs, 32'h0);
        expect_value("o_audio high cycles", audio_highs, 32'h0);

        repeat (2) begin
            value = xorshift_next();
            write_reg(PWM_BASE, value, SIZE_BYTE);
            read_reg(PWM_BASE, SIZE_BYTE, rdata);
            expect_value("o_rsp.rdata (PWM duty)", rdata, value[7:0]);
            count_pwm_highs(audio_highs, pin_highs);
            expect_value("o_audio high cycles", audio_highs, value[7:0]);
            expect_value("o_uo_out[7] high cycles", pin_highs, value[7:0]);
        end

        value = xorshift_next();
        repeat (2) begin
            write_reg(GPIO_BASE + 11'(GPIO_AUDIO), value, SIZE_WORD);
            expect_value("o_audio_select", audio_select, value[2]);
            read_reg(GPIO_BASE + 11'(GPIO_AUDIO), SIZE_WORD, rdata);
            expect_value("o_rsp.rdata (AUDIO)", rdata, value[2:0]);
            value = ~value;  // Other state of bit 2
        end

        $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== periph_hub.f ====
+incdir+verif
verilog/periph_bus_pkg.sv
verilog/periph_map_pkg.sv
verilog/gpio_ctrl.sv
verilog/crc16_engine.sv
verilog/pwm_byte.sv
verilog/periph_hub.sv
verif/tb_periph_hub.sv

// ==== Bender.yml ====
package:
  name: periph_hub

sources:
  - verilog/periph_bus_pkg.sv
  - verilog/periph_map_pkg.sv
  - verilog/gpio_ctrl.sv
  - verilog/crc16_engine.sv
  - verilog/pwm_byte.sv
  - verilog/periph_hub.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_periph_hub.sv
